/* logic/tetris_video_macros.svh */
`ifndef TETRIS_VIDEO_MACROS_SVH
`define TETRIS_VIDEO_MACROS_SVH

////////////////////////////////////////
// Raster timing, 640x480 at one pixel per clock
////////////////////////////////////////
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800    // Back porch is whatever is left
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

////////////////////////////////////////
// Playfield placement
////////////////////////////////////////
`define GRID_X0 245
`define GRID_Y0 90
`define BLOCK_SIZE 15
`define GRID_COLS 10
`define GRID_ROWS 20

////////////////////////////////////////
// Side panel placement
////////////////////////////////////////
`define PANEL_X0 420
`define PANEL_Y0 90
`define PREVIEW_CELL 15
`define BAR_X0 420
`define BAR_Y0 180
`define BAR_W 60
`define BAR_H 4        // Pixel rows per cleared line
`define LINES_MAX 50

`define RENDER_LATENCY 2   // Renderer stage plus mixer stage

`endif

/* logic/video_timing_pkg.sv */
package video_timing_pkg;

    // Raster position, wide enough for H_TOTAL and V_TOTAL
    typedef logic [9:0] pix_coord_t;

    // Sync signals as they leave the timing block
    typedef struct packed {
        logic hsync;  // Active low
        logic vsync;  // Active low
        logic de;     // High in the visible area
    } sync_bundle_t;

    // Blanking level with both syncs inactive
    localparam sync_bundle_t sync_idle = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

endpackage

/* logic/board_pkg.sv */
`include "tetris_video_macros.svh"

package board_pkg;

    // 3-bit RGB, red in the top bit
    typedef logic [2:0] color_t;

    localparam color_t color_black  = 3'b000;
    localparam color_t color_white  = 3'b111;
    localparam color_t color_red    = 3'b100;
    localparam color_t color_cyan   = 3'b011;  // Green plus blue
    localparam color_t color_yellow = 3'b110;  // Red plus green

    // One bit per cell, row 0 is the top row
    typedef logic [`GRID_ROWS-1:0][`GRID_COLS-1:0] board_t;

    // Next piece preview, row 0 on top
    typedef logic [3:0][3:0] preview_t;

    // Lines cleared so far
    typedef logic [5:0] line_count_t;

endpackage

/* logic/vga_timing.sv */
`timescale 1ns/1ps
`include "tetris_video_macros.svh"

module vga_timing import video_timing_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    output pix_coord_t   pos_x,
    output pix_coord_t   pos_y,
    output sync_bundle_t sync,
    output logic         frame_start
);

    // Sync windows
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END   = VS_START + `V_SYNC;

    pix_coord_t h_cnt;
    pix_coord_t v_cnt;
    logic       h_last;
    logic       v_last;

    assign h_last = (h_cnt == pix_coord_t'(`H_TOTAL - 1));
    assign v_last = (v_cnt == pix_coord_t'(`V_TOTAL - 1));

    ////////////////////////////////////////
    // Pixel and line counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // Wrap at frame end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Registered decode
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_x       <= '0;
            pos_y       <= '0;
            sync        <= sync_idle;  // Syncs high, de low
            frame_start <= 1'b0;
        end else begin
            pos_x      <= h_cnt;
            pos_y      <= v_cnt;
            sync.hsync <= !((h_cnt >= pix_coord_t'(HS_START)) &&
                            (h_cnt < pix_coord_t'(HS_END)));
            sync.vsync <= !((v_cnt >= pix_coord_t'(VS_START)) &&
                            (v_cnt < pix_coord_t'(VS_END)));
            sync.de    <= (h_cnt < pix_coord_t'(`H_ACTIVE)) &&
                          (v_cnt < pix_coord_t'(`V_ACTIVE));
            // First blanking line, first pixel
            frame_start <= (h_cnt == '0) && (v_cnt == pix_coord_t'(`V_ACTIVE));
        end
    end

endmodule

/* logic/tetris_grid.sv */
`timescale 1ns/1ps
`include "tetris_video_macros.svh"

module tetris_grid import video_timing_pkg::*, board_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pix_coord_t pos_x,
    input  pix_coord_t pos_y,
    input  board_t     board,
    input  logic       gameover,
    output color_t     grid_color,
    output logic       grid_hit
);

    // Playfield corners, last pixel inclusive
    localparam pix_coord_t X_FIRST = pix_coord_t'(`GRID_X0);
    localparam pix_coord_t Y_FIRST = pix_coord_t'(`GRID_Y0);
    localparam pix_coord_t X_LAST  = pix_coord_t'(`GRID_X0 + `GRID_COLS * `BLOCK_SIZE - 1);
    localparam pix_coord_t Y_LAST  = pix_coord_t'(`GRID_Y0 + `GRID_ROWS * `BLOCK_SIZE - 1);
    localparam logic [3:0] OFF_LAST = 4'(`BLOCK_SIZE - 1);

    logic [3:0] x_off;  // Pixel offset inside the cell
    logic [3:0] col;
    logic [3:0] y_off;
    logic [4:0] row;
    logic       in_grid;
    logic       on_line;
    logic       cell_set;
    color_t     color_next;

    ////////////////////////////////////////
    // Cell tracking without division
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            x_off <= '0;
            col   <= '0;
            y_off <= '0;
            row   <= '0;
        end else begin
            // Counters describe the pixel arriving next cycle
            if (pos_x == X_FIRST - 1'b1) begin
                x_off <= '0;
                col   <= '0;
            end else if (x_off == OFF_LAST) begin
                x_off <= '0;
                col   <= col + 1'b1;  // Wraps past the grid, harmless
            end else begin
                x_off <= x_off + 1'b1;
            end

            if (pos_x == pix_coord_t'(`H_TOTAL - 1)) begin  // Line step
                if (pos_y == Y_FIRST - 1'b1) begin
                    y_off <= '0;
                    row   <= '0;
                end else if (y_off == OFF_LAST) begin
                    y_off <= '0;
                    row   <= row + 1'b1;
                end else begin
                    y_off <= y_off + 1'b1;
                end
            end
        end
    end

    always_comb begin
        in_grid = (pos_x >= X_FIRST) && (pos_x <= X_LAST) &&
                  (pos_y >= Y_FIRST) && (pos_y <= Y_LAST);
        // Left/top edge of each cell plus the closing right/bottom edges
        on_line = (x_off == '0) || (y_off == '0) ||
                  (pos_x == X_LAST) || (pos_y == Y_LAST);
        cell_set = 1'b0;
        if ((row < 5'(`GRID_ROWS)) && (col < 4'(`GRID_COLS)))
            cell_set = board[row][col];

        if (!in_grid)
            color_next = color_black;
        else if (on_line)
            color_next = gameover ? color_red : color_white;
        else
            color_next = cell_set ? color_white : color_black;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grid_color <= color_black;
            grid_hit   <= 1'b0;
        end else begin
            grid_color <= color_next;
            grid_hit   <= in_grid;
        end
    end

endmodule

/* logic/side_panel.sv */
`timescale 1ns/1ps
`include "tetris_video_macros.svh"

module side_panel import video_timing_pkg::*, board_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pix_coord_t  pos_x,
    input  pix_coord_t  pos_y,
    input  preview_t    next_piece,
    input  line_count_t lines_cleared,
    output color_t      panel_color,
    output logic        panel_hit
);

    // Preview box, end bounds exclusive
    localparam pix_coord_t PV_X0 = pix_coord_t'(`PANEL_X0);
    localparam pix_coord_t PV_Y0 = pix_coord_t'(`PANEL_Y0);
    localparam pix_coord_t PV_X1 = pix_coord_t'(`PANEL_X0 + 4 * `PREVIEW_CELL);
    localparam pix_coord_t PV_Y1 = pix_coord_t'(`PANEL_Y0 + 4 * `PREVIEW_CELL);

    // Bar area, end bounds exclusive
    localparam pix_coord_t BR_X0 = pix_coord_t'(`BAR_X0);
    localparam pix_coord_t BR_Y0 = pix_coord_t'(`BAR_Y0);
    localparam pix_coord_t BR_X1 = pix_coord_t'(`BAR_X0 + `BAR_W);
    localparam pix_coord_t BR_Y1 = pix_coord_t'(`BAR_Y0 + `LINES_MAX * `BAR_H);

    logic        in_preview;
    logic        in_bar;
    logic [1:0]  pv_col;
    logic [1:0]  pv_row;
    line_count_t lines_sat;
    pix_coord_t  fill_end;
    color_t      color_next;

    // Preview cell index by comparison, only four cells
    function automatic logic [1:0] cell_of(input pix_coord_t offset);
        if (offset < pix_coord_t'(`PREVIEW_CELL))
            return 2'd0;
        else if (offset < pix_coord_t'(2 * `PREVIEW_CELL))
            return 2'd1;
        else if (offset < pix_coord_t'(3 * `PREVIEW_CELL))
            return 2'd2;
        else
            return 2'd3;
    endfunction

    ////////////////////////////////////////
    // Area decode and color pick
    ////////////////////////////////////////
    always_comb begin
        in_preview = (pos_x >= PV_X0) && (pos_x < PV_X1) &&
                     (pos_y >= PV_Y0) && (pos_y < PV_Y1);
        in_bar     = (pos_x >= BR_X0) && (pos_x < BR_X1) &&
                     (pos_y >= BR_Y0) && (pos_y < BR_Y1);
        pv_col     = cell_of(pos_x - PV_X0);  // Garbage outside, unused
        pv_row     = cell_of(pos_y - PV_Y0);

        // Bar stops growing at LINES_MAX
        lines_sat = (lines_cleared > line_count_t'(`LINES_MAX)) ?
                    line_count_t'(`LINES_MAX) : lines_cleared;
        fill_end  = BR_Y0 + pix_coord_t'(lines_sat) * pix_coord_t'(`BAR_H);

        if (in_preview)
            color_next = next_piece[pv_row][pv_col] ? color_cyan : color_black;
        else if (in_bar)
            color_next = (pos_y < fill_end) ? color_yellow : color_black;
        else
            color_next = color_black;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            panel_color <= color_black;
            panel_hit   <= 1'b0;
        end else begin
            panel_color <= color_next;
            panel_hit   <= in_preview || in_bar;
        end
    end

endmodule

/* logic/pixel_delay.sv */
`timescale 1ns/1ps

module pixel_delay #(
    parameter type      payload_t   = logic,
    parameter int       DEPTH       = 2,
    parameter payload_t RESET_VALUE = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [DEPTH];  // stages[0] is the newest

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++)
                stages[i] <= RESET_VALUE;  // Idle level during reset
        end else begin
            stages[0] <= din;
            for (int i = 1; i < DEPTH; i++)
                stages[i] <= stages[i-1];
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

/* logic/layer_mixer.sv */
`timescale 1ns/1ps

module layer_mixer import board_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  color_t grid_color,
    input  logic   grid_hit,
    input  color_t panel_color,
    input  logic   panel_hit,
    input  logic   de,
    output color_t rgb
);

    logic de_q;  // de lined up with the renderer stage

    ////////////////////////////////////////
    // Priority select and blanking
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            de_q <= 1'b0;
            rgb  <= color_black;
        end else begin
            de_q <= de;
            if (!de_q)
                rgb <= color_black;  // Blanking
            else if (grid_hit)
                rgb <= grid_color;   // Playfield on top
            else if (panel_hit)
                rgb <= panel_color;
            else
                rgb <= color_black;  // Background
        end
    end

endmodule

/* logic/tetris_display.sv */
`timescale 1ns/1ps
`include "tetris_video_macros.svh"

module tetris_display import video_timing_pkg::*, board_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  board_t      board,
    input  logic        gameover,
    input  preview_t    next_piece,
    input  line_count_t lines_cleared,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output color_t      rgb,
    output logic        frame_done
);

    pix_coord_t   pos_x;
    pix_coord_t   pos_y;
    sync_bundle_t raw_sync;
    sync_bundle_t out_sync;
    logic         frame_start;

    // Game state as seen by the renderers for a whole frame
    board_t       board_q;
    logic         gameover_q;
    preview_t     next_piece_q;
    line_count_t  lines_q;

    color_t       grid_color;
    logic         grid_hit;
    color_t       panel_color;
    logic         panel_hit;

    ////////////////////////////////////////
    // Frame latch
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            board_q      <= '0;
            gameover_q   <= 1'b0;
            next_piece_q <= '0;
            lines_q      <= '0;
        end else if (frame_start) begin  // Once per frame, in blanking
            board_q      <= board;
            gameover_q   <= gameover;
            next_piece_q <= next_piece;
            lines_q      <= lines_cleared;
        end
    end

    vga_timing u_timing (
        .clk, .rst, .pos_x, .pos_y, .sync(raw_sync), .frame_start
    );

    tetris_grid u_grid (
        .clk, .rst, .pos_x, .pos_y,
        .board(board_q), .gameover(gameover_q), .grid_color, .grid_hit
    );

    side_panel u_panel (
        .clk, .rst, .pos_x, .pos_y,
        .next_piece(next_piece_q), .lines_cleared(lines_q), .panel_color, .panel_hit
    );

    layer_mixer u_mixer (
        .clk, .rst, .grid_color, .grid_hit, .panel_color, .panel_hit,
        .de(raw_sync.de), .rgb
    );

    // Syncs follow rgb through the same latency
    pixel_delay #(
        .payload_t(sync_bundle_t), .DEPTH(`RENDER_LATENCY), .RESET_VALUE(sync_idle)
    ) u_sync_delay (
        .clk, .rst, .din(raw_sync), .dout(out_sync)
    );

    pixel_delay #(
        .payload_t(logic), .DEPTH(`RENDER_LATENCY), .RESET_VALUE(1'b0)
    ) u_frame_delay (
        .clk, .rst, .din(frame_start), .dout(frame_done)
    );

    assign hsync = out_sync.hsync;
    assign vsync = out_sync.vsync;
    assign de    = out_sync.de;

endmodule

/* testbench/tb_tetris_display.sv */
`timescale 1ns/1ps
`include "tetris_video_macros.svh"

module tb_tetris_display import board_pkg::*; ();

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int PROBE_LIMIT  = 2 * FRAME_CYCLES + `H_TOTAL;  // Target may be just past

    logic        clk = 1'b0;
    logic        rst;
    board_t      board;
    logic        gameover;
    preview_t    next_piece;
    line_count_t lines_cleared;
    logic        hsync;
    logic        vsync;
    logic        de;
    color_t      rgb;
    logic        frame_done;

    // Game state waiting to go out on SHOW or SWAP
    board_t      staged_board;
    logic        staged_gameover;
    preview_t    staged_next;
    line_count_t staged_lines;

    // Raster position as seen on the DUT outputs
    int   line_idx;
    int   col_idx;
    int   de_cnt;
    int   gap_cnt;     // Blank cycles since de last fell
    int   hs_low;
    int   vs_low;
    int   done_count;  // frame_done pulses so far
    logic de_prev;
    logic hs_prev;
    logic vs_prev;

    // Probe request and its acknowledge
    int     probe_x;
    int     probe_y;
    color_t probe_exp;
    int     probe_sent;
    int     probe_seen;

    int     pixel_errors;
    int     sync_errors;
    int     other_errors;
    logic   timed_out;
    integer seed;

    tetris_display u_dut (
        .clk, .rst, .board, .gameover, .next_piece, .lines_cleared,
        .hsync, .vsync, .de, .rgb, .frame_done
    );

    always #4 clk = ~clk;  // 8 ns period

    ////////////////////////////////////////
    // Output monitor, samples on falling edge
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            line_idx     = -1;
            col_idx      = 0;
            de_cnt       = 0;
            gap_cnt      = 0;
            hs_low       = 0;
            vs_low       = 0;
            done_count   = 0;
            probe_seen   = 0;
            pixel_errors = 0;
            sync_errors  = 0;
            de_prev      = 1'b0;
            hs_prev      = 1'b1;
            vs_prev      = 1'b1;
        end else begin
            if (!hsync)
                hs_low++;
            else if (!hs_prev) begin  // Pulse just ended
                assert (hs_low == `H_SYNC) else begin
                    sync_errors++;
                    $display("** Error hsync low cycles: expected 0x%h, got 0x%h",
                             `H_SYNC, hs_low);
                end
                hs_low = 0;
            end

            if (!vsync) begin
                if (vs_prev) begin  // Active lines of this frame are done
                    assert (line_idx + 1 == `V_ACTIVE) else begin
                        sync_errors++;
                        $display("** Error de lines: expected 0x%h, got 0x%h",
                                 `V_ACTIVE, line_idx + 1);
                    end
                    line_idx = -1;
                end
                vs_low++;
            end else if (!vs_prev) begin
                assert (vs_low == `V_SYNC * `H_TOTAL) else begin
                    sync_errors++;
                    $display("** Error vsync low cycles: expected 0x%h, got 0x%h",
                             `V_SYNC * `H_TOTAL, vs_low);
                end
                vs_low = 0;
            end

            if (de) begin
                if (!de_prev) begin  // New active line
                    line_idx++;
                    col_idx = 0;
                end else
                    col_idx++;
                de_cnt++;
                gap_cnt = 0;
                if (probe_seen != probe_sent && col_idx == probe_x && line_idx == probe_y) begin
                    assert (rgb === probe_exp) else begin
                        pixel_errors++;
                        $display("** Error rgb at (%0d,%0d): expected 0x%h, got 0x%h",
                                 probe_x, probe_y, probe_exp, rgb);
                    end
                    probe_seen = probe_sent;
                end
            end else begin
                assert (rgb === color_black) else begin
                    pixel_errors++;
                    $display("** Error rgb in blanking: expected 0x%h, got 0x%h",
                             color_black, rgb);
                end
                if (de_prev) begin
                    assert (de_cnt == `H_ACTIVE) else begin
                        sync_errors++;
                        $display("** Error de cycles: expected 0x%h, got 0x%h",
                                 `H_ACTIVE, de_cnt);
                    end
                    de_cnt = 0;
                end
                gap_cnt++;
            end

            if (frame_done) begin
                done_count++;
                // Due on the first pixel of the first blanking line
                assert (line_idx == `V_ACTIVE - 1 && gap_cnt == `H_TOTAL - `H_ACTIVE + 1)
                else begin
                    sync_errors++;
                    $display("** Error frame_done line/gap: expected 0x%h/0x%h, got 0x%h/0x%h",
                             `V_ACTIVE - 1, `H_TOTAL - `H_ACTIVE + 1, line_idx, gap_cnt);
                end
            end
            de_prev = de;
            hs_prev = hsync;
            vs_prev = vsync;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    task automatic apply_state();
        @(posedge clk);
        #1;
        board         = staged_board;
        gameover      = staged_gameover;
        next_piece    = staged_next;
        lines_cleared = staged_lines;
    endtask

    task automatic wait_done(input int count);
        int target;
        int cycles;
        target = done_count + count;
        cycles = 0;
        while (done_count < target && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > (count + 1) * FRAME_CYCLES) begin
                $display("Timeout: frame_done did not pulse %0d times", count);
                other_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_line(input int y);
        int cycles;
        cycles = 0;
        while (line_idx != y && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > FRAME_CYCLES + `H_TOTAL) begin
                $display("Timeout: active line %0d never came up", y);
                other_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // Hand one pixel to the monitor, wait until it has been compared
    task automatic probe(input int x, input int y, input color_t expected);
        int cycles;
        probe_x   = x;
        probe_y   = y;
        probe_exp = expected;
        probe_sent++;
        cycles    = 0;
        while (probe_seen != probe_sent && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles > PROBE_LIMIT) begin
                $display("Timeout: pixel (%0d,%0d) never came up on the raster", x, y);
                other_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // Random board, every cell interior checked against its bit
    task automatic check_random_board();
        int rnd;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            rnd = $random(seed);
            staged_board[r] = rnd[9:0];
        end
        apply_state();
        wait_done(2);
        for (int r = 0; r < `GRID_ROWS; r++)
            for (int c = 0; c < `GRID_COLS; c++)
                probe(`GRID_X0 + c * `BLOCK_SIZE + 7, `GRID_Y0 + r * `BLOCK_SIZE + 7,
                      staged_board[r][c] ? color_white : color_black);
    endtask

    task automatic run_record(input string text);
        string       cmd;
        int          n;
        int          a;
        int          b;
        int          c;
        logic [15:0] piece;
        n = $sscanf(text, "%s", cmd);
        if (n < 1 || cmd[0] == "#")
            return;  // Blank or comment
        if (cmd == "FRAME") begin
            n = $sscanf(text, "%s %d %h %d", cmd, a, piece, c);
            staged_board    = '0;
            staged_gameover = a[0];
            staged_next     = piece;
            staged_lines    = c[5:0];
        end else if (cmd == "ROW") begin
            n = $sscanf(text, "%s %d %h", cmd, a, b);
            staged_board[a] = b[9:0];
        end else if (cmd == "SHOW") begin
            apply_state();
            wait_done(2);  // Latched, then a full frame drawn
        end else if (cmd == "WAIT") begin
            n = $sscanf(text, "%s %d", cmd, a);
            wait_done(a);
        end else if (cmd == "SWAP") begin  // Change inputs mid-frame
            n = $sscanf(text, "%s %d", cmd, a);
            wait_line(a);
            apply_state();
        end else if (cmd == "PROBE") begin
            n = $sscanf(text, "%s %d %d %h", cmd, a, b, c);
            probe(a, b, color_t'(c));
        end else if (cmd == "RANDOM")
            check_random_board();
        else begin
            $display("Unknown record in test data: %s", cmd);
            other_errors++;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int    fd;
        string text;
        rst             = 1'b1;
        board           = '0;
        gameover        = 1'b0;
        next_piece      = '0;
        lines_cleared   = '0;
        staged_board    = '0;
        staged_gameover = 1'b0;
        staged_next     = '0;
        staged_lines    = '0;
        probe_x         = 0;
        probe_y         = 0;
        probe_exp       = color_black;
        probe_sent      = 0;
        other_errors    = 0;
        timed_out       = 1'b0;
        seed            = 32'h187f;

        // Idle outputs throughout reset
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            assert (rgb === color_black && hsync === 1'b1 && vsync === 1'b1 &&
                    de === 1'b0 && frame_done === 1'b0)
            else begin
                other_errors++;
                $display("** Error reset outputs: rgb 0x%h hsync 0x%h vsync 0x%h de 0x%h %s 0x%h",
                         rgb, hsync, vsync, de, "frame_done", frame_done);
            end
        end
        rst = 1'b0;

        fd = $fopen("testbench/display_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/display_tests.txt");
            other_errors++;
        end else begin
            while (!timed_out && $fgets(text, fd) > 0)
                run_record(text);
            $fclose(fd);
        end

        $display("Probes: %0d, errors: pixel %0d, sync %0d, other %0d",
                 probe_seen, pixel_errors, sync_errors, other_errors);
        if (pixel_errors + sync_errors + other_errors == 0 && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/video_timing_pkg.sv
logic/board_pkg.sv
logic/vga_timing.sv
logic/tetris_grid.sv
logic/side_panel.sv
logic/pixel_delay.sv
logic/layer_mixer.sv
logic/tetris_display.sv
testbench/tb_tetris_display.sv

/* Makefile */
# Verilator build and run for the tetris display testbench

VERILATOR ?= verilator
TOP       ?= tb_tetris_display
OBJ_DIR   ?= obj_dir
FILE_LIST ?= build.f
VFLAGS    ?= --binary --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Runs from the project root so the test data path resolves
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/display_tests.txt */
# FRAME gameover next_piece(hex, nibble n is preview row n) lines_cleared(dec)
# ROW row bits(hex, bit 0 is the left column)   SHOW   WAIT frames   SWAP output_line
# RANDOM   PROBE x y expected_rgb(hex)
FRAME 0 0660 5
ROW 0 001
ROW 18 201
ROW 19 3ff
SHOW
PROBE 245 90 7
PROBE 252 97 7
PROBE 267 97 0
PROBE 427 97 0
PROBE 100 100 0
PROBE 442 112 3
PROBE 430 165 0
PROBE 440 199 6
PROBE 394 200 7
PROBE 440 200 0
PROBE 327 367 0
PROBE 312 382 7
FRAME 1 000f 63
ROW 5 0aa
SHOW
PROBE 245 90 4
PROBE 472 97 3
PROBE 427 112 0
PROBE 267 172 7
PROBE 260 200 4
PROBE 470 379 6
PROBE 470 380 0
FRAME 0 0000 0
SHOW
FRAME 0 0000 10
ROW 7 3ff
SWAP 100
PROBE 312 202 0
PROBE 440 210 0
WAIT 1
PROBE 312 202 7
PROBE 440 210 6
FRAME 0 0000 0
RANDOM
